// ==== logic/ni_pkg.sv ====
/*
 * Shared definitions of the slave network interface
 * Widths, flit layout, buffer depths and FSM states
 */
package ni_pkg;

	// ************************************************************
	// Widths and plain vector types
	// ************************************************************
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int LEN_W = 4;
	localparam int RESP_W = 2;
	localparam int FLIT_W = 40;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [RESP_W-1:0] resp_t;
	typedef logic [FLIT_W-1:0] flit_t;
	typedef logic [1:0] flit_kind_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	localparam flit_kind_t FLIT_HEAD = 2'd1;
	localparam flit_kind_t FLIT_DATA = 2'd2;

	// ************************************************************
	// Flit layout, unused bits are zero
	// ************************************************************
	// Kind sits in [39:38]
	localparam int FLIT_KIND_LSB = 38;
	// Write bit in head flits, last bit in data flits
	localparam int FLIT_FLAG_BIT = 36;
	// Request flits: len or strb in [35:32]
	// Response flits: resp in [33:32]
	localparam int FLIT_MID_LSB = 32;
	// Low bits hold addr, data, or the response len in [3:0]

	// Buffer depths
	localparam int NUM_CMD_BUFFER = 2;
	localparam int NUM_WDATA_BUFFER = 2;

	// ************************************************************
	// FSM states
	// ************************************************************
	typedef enum logic [1:0] {BR_IDLE, BR_ISSUE, BR_WAIT_REPLY} bridge_state_e;
	typedef enum logic [1:0] {PKT_IDLE, PKT_HEAD, PKT_DATA} pkt_state_e;

endpackage

// ==== logic/ni_channel_if.sv ====
/*
 * Internal channels of the slave network interface
 * Request side carries commands and write beats, response side carries replies
 */
`timescale 1ns/1ps

interface ni_req_if;
	// Command group
	logic cmd_valid;
	logic cmd_ready;
	logic cmd_write;
	ni_pkg::addr_t cmd_addr;
	ni_pkg::len_t cmd_len;

	// Write-beat group
	logic wd_valid;
	logic wd_ready;
	ni_pkg::data_t wd_data;
	ni_pkg::strb_t wd_strb;
	logic wd_last;

	modport src (
		output cmd_valid, cmd_write, cmd_addr, cmd_len,
		input cmd_ready,
		output wd_valid, wd_data, wd_strb, wd_last,
		input wd_ready
	);

	modport dst (
		input cmd_valid, cmd_write, cmd_addr, cmd_len,
		output cmd_ready,
		input wd_valid, wd_data, wd_strb, wd_last,
		output wd_ready
	);
endinterface

interface ni_rsp_if;
	logic rsp_valid;
	logic rsp_ready;
	logic rsp_write;
	ni_pkg::resp_t rsp_resp;
	ni_pkg::data_t rsp_data;
	logic rsp_last;

	modport src (output rsp_valid, rsp_write, rsp_resp, rsp_data, rsp_last, input rsp_ready);
	modport dst (input rsp_valid, rsp_write, rsp_resp, rsp_data, rsp_last, output rsp_ready);
endinterface

// ==== logic/ni_fifo.sv ====
/*
 * Small synchronous ring buffer with valid/ready on both sides
 */
`timescale 1ns/1ps

module ni_fifo #(
	parameter int DEPTH = 2,
	parameter int WIDTH = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic [WIDTH-1:0] in_data,
	output logic in_ready,
	output logic out_valid,
	output logic [WIDTH-1:0] out_data,
	input  logic out_ready
);
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push;
	logic pop;

	assign in_ready = (count != CW'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// Pointers wrap at DEPTH, so any depth works
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== logic/ni_req_depacketizer.sv ====
/*
 * Request depacketizer
 * Splits request packets into buffered commands and write beats
 */
`timescale 1ns/1ps

module ni_req_depacketizer (
	input  logic clk,
	input  logic rst,
	input  logic comm_disable,
	input  logic rfni_valid,
	input  ni_pkg::flit_t rfni_flit,
	output logic rfni_ready,
	ni_req_if.src req
);
	localparam int CMD_W = 1 + ni_pkg::LEN_W + ni_pkg::ADDR_W;
	localparam int WD_W = 1 + ni_pkg::STRB_W + ni_pkg::DATA_W;

	ni_pkg::flit_kind_t kind;
	logic flag;
	logic in_pkt;
	logic take;
	logic cmd_push;
	logic cmd_space;
	logic wd_push;
	logic wd_space;
	logic [CMD_W-1:0] cmd_in;
	logic [CMD_W-1:0] cmd_out;
	logic [WD_W-1:0] wd_in;
	logic [WD_W-1:0] wd_out;

	// ************************************************************
	// Flit decode
	// ************************************************************
	assign kind = rfni_flit[ni_pkg::FLIT_KIND_LSB +: 2];
	assign flag = rfni_flit[ni_pkg::FLIT_FLAG_BIT];

	// Head: write, len, addr
	assign cmd_in = {flag, rfni_flit[ni_pkg::FLIT_MID_LSB +: ni_pkg::LEN_W],
		rfni_flit[ni_pkg::ADDR_W-1:0]};
	// Data: last, strb, data
	assign wd_in = {flag, rfni_flit[ni_pkg::FLIT_MID_LSB +: ni_pkg::STRB_W],
		rfni_flit[ni_pkg::DATA_W-1:0]};

	// Between packets only a head is expected
	// comm_disable holds the link off there
	always_comb begin
		if (in_pkt) begin
			rfni_ready = wd_space;
		end else begin
			rfni_ready = cmd_space && !comm_disable;
		end
	end

	assign take = rfni_valid && rfni_ready;
	// Stray flits of the wrong kind are taken and dropped
	assign cmd_push = take && !in_pkt && (kind == ni_pkg::FLIT_HEAD);
	assign wd_push = take && in_pkt && (kind == ni_pkg::FLIT_DATA);

	// A write head opens a packet, the last data flit closes it
	always_ff @(posedge clk) begin
		if (rst) begin
			in_pkt <= 1'b0;
		end else if (cmd_push && flag) begin
			in_pkt <= 1'b1;
		end else if (wd_push && flag) begin
			in_pkt <= 1'b0;
		end
	end

	// ************************************************************
	// Command and write-beat buffers
	// ************************************************************
	ni_fifo #(
		.DEPTH(ni_pkg::NUM_CMD_BUFFER),
		.WIDTH(CMD_W)
	) cmd_fifo (
		.clk(clk),
		.rst(rst),
		.in_valid(cmd_push),
		.in_data(cmd_in),
		.in_ready(cmd_space),
		.out_valid(req.cmd_valid),
		.out_data(cmd_out),
		.out_ready(req.cmd_ready)
	);

	ni_fifo #(
		.DEPTH(ni_pkg::NUM_WDATA_BUFFER),
		.WIDTH(WD_W)
	) wd_fifo (
		.clk(clk),
		.rst(rst),
		.in_valid(wd_push),
		.in_data(wd_in),
		.in_ready(wd_space),
		.out_valid(req.wd_valid),
		.out_data(wd_out),
		.out_ready(req.wd_ready)
	);

	assign {req.cmd_write, req.cmd_len, req.cmd_addr} = cmd_out;
	assign {req.wd_last, req.wd_strb, req.wd_data} = wd_out;

endmodule

// ==== logic/ni_rsp_packetizer.sv ====
/*
 * Response packetizer
 * Packs slave replies into response head and data flits
 */
`timescale 1ns/1ps

module ni_rsp_packetizer (
	input  logic clk,
	input  logic rst,
	ni_rsp_if.dst rsp,
	output logic rbni_valid,
	output ni_pkg::flit_t rbni_flit,
	input  logic rbni_ready
);
	ni_pkg::pkt_state_e state;
	logic wr_q;
	logic out_free;
	logic load_head;
	logic load_data;
	ni_pkg::flit_t head_flit;
	ni_pkg::flit_t data_flit;

	// Output register can take a new flit
	assign out_free = !rbni_valid || rbni_ready;

	// A write reply is dropped once its head is out, read beats become data flits
	always_comb begin
		case (state)
			ni_pkg::PKT_HEAD: rsp.rsp_ready = wr_q && out_free;
			ni_pkg::PKT_DATA: rsp.rsp_ready = out_free;
			default: rsp.rsp_ready = 1'b0;
		endcase
	end

	// The head is built from the first reply without taking it
	assign load_head = (state == ni_pkg::PKT_IDLE) && rsp.rsp_valid && out_free;
	assign load_data = (state == ni_pkg::PKT_DATA) && rsp.rsp_valid && rsp.rsp_ready;

	always_comb begin
		head_flit = '0;
		head_flit[ni_pkg::FLIT_KIND_LSB +: 2] = ni_pkg::FLIT_HEAD;
		head_flit[ni_pkg::FLIT_FLAG_BIT] = rsp.rsp_write;
		head_flit[ni_pkg::FLIT_MID_LSB +: ni_pkg::RESP_W] = rsp.rsp_resp;
		// Len field is zero, no beats are counted at head time

		data_flit = '0;
		data_flit[ni_pkg::FLIT_KIND_LSB +: 2] = ni_pkg::FLIT_DATA;
		data_flit[ni_pkg::FLIT_FLAG_BIT] = rsp.rsp_last;
		data_flit[ni_pkg::FLIT_MID_LSB +: ni_pkg::RESP_W] = rsp.rsp_resp;
		data_flit[ni_pkg::DATA_W-1:0] = rsp.rsp_data;
	end

	// ************************************************************
	// Packet FSM and output register
	// ************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ni_pkg::PKT_IDLE;
			wr_q <= 1'b0;
			rbni_valid <= 1'b0;
		end else begin
			if (load_head || load_data) begin
				rbni_valid <= 1'b1;
			end else if (rbni_ready) begin
				rbni_valid <= 1'b0;
			end
			case (state)
				ni_pkg::PKT_IDLE: begin
					if (load_head) begin
						wr_q <= rsp.rsp_write;
						state <= ni_pkg::PKT_HEAD;
					end
				end
				ni_pkg::PKT_HEAD: begin
					if (!wr_q) begin
						state <= ni_pkg::PKT_DATA;
					end else if (rsp.rsp_valid && rsp.rsp_ready) begin
						state <= ni_pkg::PKT_IDLE;
					end
				end
				ni_pkg::PKT_DATA: begin
					if (load_data && rsp.rsp_last) begin
						state <= ni_pkg::PKT_IDLE;
					end
				end
				default: state <= ni_pkg::PKT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_head) begin
			rbni_flit <= head_flit;
		end else if (load_data) begin
			rbni_flit <= data_flit;
		end
	end

endmodule

// ==== logic/lpi_slave_bridge.sv ====
/*
 * Command to queue-style slave bridge
 * Issues one q beat per word and forwards y replies as responses
 */
`timescale 1ns/1ps

module lpi_slave_bridge (
	input  logic clk,
	input  logic rst,
	ni_req_if.dst req,
	ni_rsp_if.src rsp,

	// Request channel
	output logic slxq_valid,
	input  logic slxq_ready,
	output logic slxq_write,
	output ni_pkg::addr_t slxq_addr,
	output ni_pkg::len_t slxq_len,
	output ni_pkg::data_t slxq_wdata,
	output ni_pkg::strb_t slxq_wstrb,
	output logic slxq_last,

	// Reply channel
	input  logic slxy_valid,
	output logic slxy_ready,
	input  logic slxy_wreply,
	input  ni_pkg::resp_t slxy_resp,
	input  ni_pkg::data_t slxy_rdata,
	input  logic slxy_last
);
	ni_pkg::bridge_state_e state;
	logic write_q;
	ni_pkg::addr_t addr_q;
	ni_pkg::len_t len_q;
	ni_pkg::len_t beats_left;
	logic cmd_fire;
	logic q_fire;
	logic y_done;

	// ************************************************************
	// Request side
	// ************************************************************
	assign req.cmd_ready = (state == ni_pkg::BR_IDLE);
	assign cmd_fire = req.cmd_valid && req.cmd_ready;

	// A write beat waits for its data word
	assign slxq_valid = (state == ni_pkg::BR_ISSUE) && (!write_q || req.wd_valid);
	assign slxq_write = write_q;
	assign slxq_addr = addr_q;
	assign slxq_len = len_q;
	assign slxq_wdata = write_q ? req.wd_data : '0;
	assign slxq_wstrb = write_q ? req.wd_strb : '0;
	// Burst ends on the counted beat, or early if the write packet ran short
	assign slxq_last = (beats_left == '0) || (write_q && req.wd_last);
	assign q_fire = slxq_valid && slxq_ready;

	// Each write q beat takes one write beat
	assign req.wd_ready = (state == ni_pkg::BR_ISSUE) && write_q && slxq_ready;

	// ************************************************************
	// Reply side
	// ************************************************************
	assign slxy_ready = (state == ni_pkg::BR_WAIT_REPLY) && rsp.rsp_ready;
	assign rsp.rsp_valid = (state == ni_pkg::BR_WAIT_REPLY) && slxy_valid;
	assign rsp.rsp_write = slxy_wreply;
	assign rsp.rsp_resp = slxy_resp;
	assign rsp.rsp_data = slxy_rdata;
	assign rsp.rsp_last = slxy_last;

	// One write reply, or read replies up to the one with last
	assign y_done = slxy_valid && slxy_ready && (slxy_wreply || slxy_last);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ni_pkg::BR_IDLE;
			write_q <= 1'b0;
			beats_left <= '0;
		end else begin
			case (state)
				ni_pkg::BR_IDLE: begin
					if (cmd_fire) begin
						write_q <= req.cmd_write;
						beats_left <= req.cmd_len;
						state <= ni_pkg::BR_ISSUE;
					end
				end
				ni_pkg::BR_ISSUE: begin
					if (q_fire) begin
						beats_left <= beats_left - 1'b1;
						if (slxq_last) begin
							state <= ni_pkg::BR_WAIT_REPLY;
						end
					end
				end
				ni_pkg::BR_WAIT_REPLY: begin
					if (y_done) begin
						state <= ni_pkg::BR_IDLE;
					end
				end
				default: state <= ni_pkg::BR_IDLE;
			endcase
		end
	end

	// Address steps one word per beat
	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			addr_q <= req.cmd_addr;
			len_q <= req.cmd_len;
		end else if (q_fire) begin
			addr_q <= addr_q + ni_pkg::addr_t'(ni_pkg::STRB_W);
		end
	end

endmodule

// ==== logic/slave_ni_top.sv ====
/*
 * Slave network interface top
 * Depacketizer, slave bridge and packetizer joined by the internal channels
 */
`timescale 1ns/1ps

module slave_ni_top (
	input  logic clk,
	input  logic rst,
	input  logic comm_disable,

	// Request link from the router
	input  logic rfni_valid,
	input  ni_pkg::flit_t rfni_flit,
	output logic rfni_ready,

	// Response link to the router
	output logic rbni_valid,
	output ni_pkg::flit_t rbni_flit,
	input  logic rbni_ready,

	// Slave request channel
	output logic slxq_valid,
	input  logic slxq_ready,
	output logic slxq_write,
	output ni_pkg::addr_t slxq_addr,
	output ni_pkg::len_t slxq_len,
	output ni_pkg::data_t slxq_wdata,
	output ni_pkg::strb_t slxq_wstrb,
	output logic slxq_last,

	// Slave reply channel
	input  logic slxy_valid,
	output logic slxy_ready,
	input  logic slxy_wreply,
	input  ni_pkg::resp_t slxy_resp,
	input  ni_pkg::data_t slxy_rdata,
	input  logic slxy_last
);
	ni_req_if req_ch ();
	ni_rsp_if rsp_ch ();

	ni_req_depacketizer depack0 (
		.clk(clk),
		.rst(rst),
		.comm_disable(comm_disable),
		.rfni_valid(rfni_valid),
		.rfni_flit(rfni_flit),
		.rfni_ready(rfni_ready),
		.req(req_ch.src)
	);

	lpi_slave_bridge bridge0 (
		.clk(clk),
		.rst(rst),
		.req(req_ch.dst),
		.rsp(rsp_ch.src),
		.slxq_valid(slxq_valid),
		.slxq_ready(slxq_ready),
		.slxq_write(slxq_write),
		.slxq_addr(slxq_addr),
		.slxq_len(slxq_len),
		.slxq_wdata(slxq_wdata),
		.slxq_wstrb(slxq_wstrb),
		.slxq_last(slxq_last),
		.slxy_valid(slxy_valid),
		.slxy_ready(slxy_ready),
		.slxy_wreply(slxy_wreply),
		.slxy_resp(slxy_resp),
		.slxy_rdata(slxy_rdata),
		.slxy_last(slxy_last)
	);

	ni_rsp_packetizer pack0 (
		.clk(clk),
		.rst(rst),
		.rsp(rsp_ch.dst),
		.rbni_valid(rbni_valid),
		.rbni_flit(rbni_flit),
		.rbni_ready(rbni_ready)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset, 100 ns period
 */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset drops on a falling edge after the reset cycles
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== testbench/slave_ni_checker.sv ====
/*
 * Handshake assertions on the network and slave ports
 */
`timescale 1ns/1ps

module slave_ni_checker (
	input  logic clk,
	input  logic rst,
	input  logic rbni_valid,
	input  logic rbni_ready,
	input  ni_pkg::flit_t rbni_flit,
	input  logic slxq_valid,
	input  logic slxq_ready,
	input  logic slxq_write,
	input  ni_pkg::addr_t slxq_addr,
	input  ni_pkg::len_t slxq_len,
	input  ni_pkg::data_t slxq_wdata,
	input  ni_pkg::strb_t slxq_wstrb,
	input  logic slxq_last
);
	// Response flit holds under back-pressure
	rbni_hold: assert property (@(posedge clk) disable iff (rst)
		rbni_valid && !rbni_ready |=> rbni_valid && $stable(rbni_flit))
		else $error("rbni_flit changed while waiting for rbni_ready");

	// Whole q beat holds until the slave takes it
	slxq_hold: assert property (@(posedge clk) disable iff (rst)
		slxq_valid && !slxq_ready |=> slxq_valid && $stable({slxq_write, slxq_addr,
		slxq_len, slxq_wdata, slxq_wstrb, slxq_last}))
		else $error("q beat changed while waiting for slxq_ready");

	// Outputs quiet once reset has been seen
	reset_quiet: assert property (@(posedge clk)
		rst |=> !slxq_valid && !rbni_valid)
		else $error("valid raised during reset");

endmodule

bind slave_ni_top slave_ni_checker checker0 (.*);

// ==== testbench/slave_ni_tb.sv ====
/*
 * Testbench of the slave network interface
 * Table of bursts, slave memory model, network driver and monitor
 */
`timescale 1ns/1ps

module slave_ni_tb;
	localparam int NUM_ROWS = 11;
	localparam int MEM_WORDS = 256;
	localparam int WAIT_LIMIT = 500;
	localparam int HOLD_CYCLES = 6;
	// Settled point, ten ns before the rising edge
	localparam int SAMPLE_DELAY = 40;
	localparam logic [31:0] LCG_SEED = 32'd71533;
	// Slave answers with an error at and above this address
	localparam ni_pkg::addr_t ERR_LIMIT = 32'h0000_0300;

	typedef struct packed {
		logic wr;
		ni_pkg::addr_t addr;
		ni_pkg::len_t len;
		logic [31:0] seed;
		logic dis;
		logic bp;
	} row_t;

	typedef struct packed {
		logic write;
		logic last;
		ni_pkg::len_t len;
		ni_pkg::strb_t strb;
		ni_pkg::data_t data;
		ni_pkg::addr_t addr;
	} q_beat_t;

	logic clk;
	logic rst;
	logic comm_disable;
	logic rfni_valid;
	ni_pkg::flit_t rfni_flit;
	logic rfni_ready;
	logic rbni_valid;
	ni_pkg::flit_t rbni_flit;
	logic rbni_ready;
	logic slxq_valid;
	logic slxq_ready;
	logic slxq_write;
	ni_pkg::addr_t slxq_addr;
	ni_pkg::len_t slxq_len;
	ni_pkg::data_t slxq_wdata;
	ni_pkg::strb_t slxq_wstrb;
	logic slxq_last;
	logic slxy_valid;
	logic slxy_ready;
	logic slxy_wreply;
	ni_pkg::resp_t slxy_resp;
	ni_pkg::data_t slxy_rdata;
	logic slxy_last;

	row_t rows [NUM_ROWS];
	ni_pkg::data_t slave_mem [MEM_WORDS];
	ni_pkg::data_t ref_mem [MEM_WORDS];
	q_beat_t q_log [$];
	ni_pkg::flit_t rsp_log [$];
	// Pending y replies: wreply, resp, data, last
	logic [35:0] reply_q [$];
	logic [31:0] lcg_state;
	logic bp_on;
	logic wr_err;
	int errors;
	int tests_failed;

	tb_clock_gen clk_gen0 (.clk(clk), .rst(rst));

	slave_ni_top dut0 (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic ni_pkg::data_t fill_word(input int idx);
		return 32'hC0DE_0000 ^ (32'(idx) * 32'h0009_E377);
	endfunction

	function automatic ni_pkg::data_t beat_data(input logic [31:0] seed, input int i);
		return seed ^ (32'h0101_0101 * 32'(i + 1));
	endfunction

	// Mostly full words, every third beat partial
	function automatic ni_pkg::strb_t beat_strb(input logic [31:0] seed, input int i);
		return (i % 3 == 1) ? (seed[3:0] | 4'b0001) : 4'hF;
	endfunction

	function automatic ni_pkg::data_t merge_word(input ni_pkg::data_t old_w,
		input ni_pkg::data_t new_w, input ni_pkg::strb_t strb);
		ni_pkg::data_t w;
		int b;
		w = old_w;
		for (b = 0; b < 4; b++) begin
			if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
		end
		return w;
	endfunction

	// Kind on top, one flag bit, a 4-bit middle field, then the low word
	function automatic ni_pkg::flit_t make_flit(input ni_pkg::flit_kind_t kind, input logic flag,
		input logic [3:0] mid, input logic [31:0] low);
		ni_pkg::flit_t f;
		f = '0;
		f[ni_pkg::FLIT_KIND_LSB +: 2] = kind;
		f[ni_pkg::FLIT_FLAG_BIT] = flag;
		f[ni_pkg::FLIT_MID_LSB +: 4] = mid;
		f[31:0] = low;
		return f;
	endfunction

	task automatic load_table();
		// wr, addr, len, data seed, comm_disable pulse, back-pressure
		rows[0] = {1'b1, 32'h0000_0040, 4'd3, 32'h1111_2226, 1'b0, 1'b0};
		rows[1] = {1'b0, 32'h0000_0040, 4'd3, 32'h0000_0000, 1'b0, 1'b0};
		rows[2] = {1'b1, 32'h0000_0100, 4'd0, 32'h3C3C_5A5A, 1'b1, 1'b0};
		rows[3] = {1'b0, 32'h0000_00FC, 4'd2, 32'h0000_0000, 1'b0, 1'b0};
		rows[4] = {1'b1, 32'h0000_0080, 4'd7, 32'h7E57_0009, 1'b0, 1'b1};
		rows[5] = {1'b0, 32'h0000_0080, 4'd7, 32'h0000_0000, 1'b0, 1'b1};
		rows[6] = {1'b1, 32'h0000_02F8, 4'd3, 32'hBEEF_0004, 1'b0, 1'b0};
		rows[7] = {1'b0, 32'h0000_02F8, 4'd3, 32'h0000_0000, 1'b0, 1'b1};
		rows[8] = {1'b0, 32'h0000_0340, 4'd1, 32'h0000_0000, 1'b1, 1'b1};
		rows[9] = {1'b1, 32'h0000_0010, 4'd15, 32'h0F0F_1232, 1'b0, 1'b1};
		rows[10] = {1'b0, 32'h0000_0010, 4'd15, 32'h0000_0000, 1'b1, 1'b1};
	endtask

	task automatic report_fail(input string msg);
		$display("Fail at time %0t: %s", $time, msg);
		errors++;
	endtask

	// ************************************************************
	// Slave model and response monitor
	// ************************************************************
	// Handshakes are seen just before the rising edge that completes them
	always begin
		@(negedge clk);
		#SAMPLE_DELAY;
		if (!rst) begin
			if (slxq_valid && slxq_ready) begin
				q_log.push_back({slxq_write, slxq_last, slxq_len, slxq_wstrb, slxq_wdata, slxq_addr});
				if (slxq_write) begin
					if (slxq_addr >= ERR_LIMIT) begin
						wr_err = 1'b1;
					end else begin
						slave_mem[slxq_addr[9:2]] = merge_word(slave_mem[slxq_addr[9:2]],
							slxq_wdata, slxq_wstrb);
					end
					if (slxq_last) begin
						reply_q.push_back({1'b1, (wr_err ? ni_pkg::RESP_SLVERR : ni_pkg::RESP_OKAY),
							32'h0, 1'b1});
						wr_err = 1'b0;
					end
				end else if (slxq_addr >= ERR_LIMIT) begin
					reply_q.push_back({1'b0, ni_pkg::RESP_SLVERR, 32'h0, slxq_last});
				end else begin
					reply_q.push_back({1'b0, ni_pkg::RESP_OKAY, slave_mem[slxq_addr[9:2]], slxq_last});
				end
			end
			if (slxy_valid && slxy_ready) reply_q.pop_front();
			if (rbni_valid && rbni_ready) rsp_log.push_back(rbni_flit);
		end
	end

	// Ready levels and y replies change on the falling edge
	always @(negedge clk) begin
		if (rst) begin
			slxq_ready = 1'b0;
			rbni_ready = 1'b0;
			slxy_valid = 1'b0;
		end else begin
			lcg_state = lcg_next(lcg_state);
			slxq_ready = bp_on ? lcg_state[30] : 1'b1;
			lcg_state = lcg_next(lcg_state);
			rbni_ready = bp_on ? lcg_state[30] : 1'b1;
			if (reply_q.size() > 0) begin
				slxy_valid = 1'b1;
				{slxy_wreply, slxy_resp, slxy_rdata, slxy_last} = reply_q[0];
			end else begin
				slxy_valid = 1'b0;
			end
		end
	end

	// ************************************************************
	// Request link driver
	// ************************************************************
	task automatic send_flit(input ni_pkg::flit_t f, output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		rfni_valid = 1'b1;
		rfni_flit = f;
		while (!ok && n < WAIT_LIMIT) begin
			#SAMPLE_DELAY;
			ok = rfni_ready;
			n++;
			@(negedge clk);
		end
		rfni_valid = 1'b0;
		if (!ok) begin
			$display("Timeout at time %0t: the request link never took a flit", $time);
			errors++;
		end
	endtask

	// Head waits at the link while the interface is disabled
	task automatic hold_disabled(input ni_pkg::flit_t head);
		comm_disable = 1'b1;
		rfni_valid = 1'b1;
		rfni_flit = head;
		repeat (HOLD_CYCLES) begin
			#SAMPLE_DELAY;
			if (rfni_ready !== 1'b0) report_fail("rfni_ready high while comm_disable is set");
			@(negedge clk);
			if (q_log.size() != 0) report_fail("q beat issued while comm_disable is set");
		end
		comm_disable = 1'b0;
	endtask

	task automatic run_row(input int r);
		row_t row;
		q_beat_t beat;
		ni_pkg::flit_t exp_flit;
		ni_pkg::data_t exp_data;
		ni_pkg::resp_t exp_resp;
		ni_pkg::addr_t a;
		logic ok;
		logic werr;
		int i;
		int n;
		int nflits;
		int err_before;
		row = rows[r];
		err_before = errors;
		bp_on <= row.bp;
		q_log.delete();
		rsp_log.delete();
		nflits = row.wr ? 1 : int'(row.len) + 2;
		if (row.dis) hold_disabled(make_flit(ni_pkg::FLIT_HEAD, row.wr, row.len, row.addr));
		send_flit(make_flit(ni_pkg::FLIT_HEAD, row.wr, row.len, row.addr), ok);
		for (i = 0; ok && row.wr && i <= int'(row.len); i++) begin
			send_flit(make_flit(ni_pkg::FLIT_DATA, i == int'(row.len), beat_strb(row.seed, i),
				beat_data(row.seed, i)), ok);
		end
		n = 0;
		while (ok && rsp_log.size() < nflits && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (ok && rsp_log.size() < nflits) begin
			$display("Timeout at time %0t: response packet of test %0d is incomplete", $time, r);
			errors++;
			ok = 1'b0;
		end
		if (ok) begin
			// Request channel beats
			if (q_log.size() != int'(row.len) + 1) begin
				report_fail($sformatf("%0d q beats seen, %0d expected", q_log.size(), row.len + 1));
			end else begin
				for (i = 0; i <= int'(row.len); i++) begin
					beat = q_log[i];
					if (beat.addr !== row.addr + 32'(4 * i) || beat.write !== row.wr ||
						beat.len !== row.len || beat.last !== (i == int'(row.len)))
						report_fail($sformatf("q beat %0d addr %h write %b len %0d last %b",
							i, beat.addr, beat.write, beat.len, beat.last));
					if (row.wr && (beat.data !== beat_data(row.seed, i) ||
						beat.strb !== beat_strb(row.seed, i)))
						report_fail($sformatf("q beat %0d wdata %h wstrb %b", i, beat.data, beat.strb));
				end
			end
			// Response flits against the reference memory
			werr = 1'b0;
			for (i = 0; i <= int'(row.len); i++) begin
				a = row.addr + 32'(4 * i);
				exp_resp = (a >= ERR_LIMIT) ? ni_pkg::RESP_SLVERR : ni_pkg::RESP_OKAY;
				exp_data = (a >= ERR_LIMIT) ? '0 : ref_mem[a[9:2]];
				if (row.wr) begin
					if (a >= ERR_LIMIT) werr = 1'b1;
					else ref_mem[a[9:2]] = merge_word(exp_data, beat_data(row.seed, i),
						beat_strb(row.seed, i));
				end else begin
					if (i == 0) begin
						exp_flit = make_flit(ni_pkg::FLIT_HEAD, 1'b0, {2'b00, exp_resp}, '0);
						if (rsp_log[0] !== exp_flit)
							report_fail($sformatf("read head flit %h, expected %h", rsp_log[0], exp_flit));
					end
					exp_flit = make_flit(ni_pkg::FLIT_DATA, i == int'(row.len), {2'b00, exp_resp}, exp_data);
					if (rsp_log[i + 1] !== exp_flit)
						report_fail($sformatf("read data flit %0d is %h, expected %h",
							i, rsp_log[i + 1], exp_flit));
				end
			end
			if (row.wr) begin
				exp_resp = werr ? ni_pkg::RESP_SLVERR : ni_pkg::RESP_OKAY;
				exp_flit = make_flit(ni_pkg::FLIT_HEAD, 1'b1, {2'b00, exp_resp}, '0);
				if (rsp_log[0] !== exp_flit)
					report_fail($sformatf("write head flit %h, expected %h", rsp_log[0], exp_flit));
			end
		end
		if (errors != err_before) tests_failed++;
		$display("Test %0d: %s at 0x%08h, %0d beats, %s", r, row.wr ? "write" : "read", row.addr,
			row.len + 1, (errors == err_before) ? "passed" : "failed");
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************
	initial begin
		int n;
		int r;
		comm_disable = 1'b0;
		rfni_valid = 1'b0;
		rfni_flit = '0;
		rbni_ready = 1'b0;
		slxq_ready = 1'b0;
		slxy_valid = 1'b0;
		slxy_wreply = 1'b0;
		slxy_resp = '0;
		slxy_rdata = '0;
		slxy_last = 1'b0;
		bp_on = 1'b0;
		wr_err = 1'b0;
		lcg_state = LCG_SEED;
		errors = 0;
		tests_failed = 0;
		load_table();
		for (n = 0; n < MEM_WORDS; n++) begin
			slave_mem[n] = fill_word(n);
			ref_mem[n] = fill_word(n);
		end
		n = 0;
		@(negedge clk);
		while (rst !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			$display("Timeout at time %0t: reset was never released", $time);
			errors++;
		end else begin
			for (r = 0; r < NUM_ROWS; r++) run_row(r);
		end
		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
			NUM_ROWS, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
logic/ni_pkg.sv
logic/ni_channel_if.sv
logic/ni_fifo.sv
logic/ni_req_depacketizer.sv
logic/ni_rsp_packetizer.sv
logic/lpi_slave_bridge.sv
logic/slave_ni_top.sv
testbench/tb_clock_gen.sv
testbench/slave_ni_checker.sv
testbench/slave_ni_tb.sv

// ==== Bender.yml ====
package:
  name: slave_ni

sources:
  - logic/ni_pkg.sv
  - logic/ni_channel_if.sv
  - logic/ni_fifo.sv
  - logic/ni_req_depacketizer.sv
  - logic/ni_rsp_packetizer.sv
  - logic/lpi_slave_bridge.sv
  - logic/slave_ni_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/slave_ni_checker.sv
      - testbench/slave_ni_tb.sv
